/* sources.f */
+incdir+common
common/linear_pkg.sv
logic/matrix_stream_transpose.sv
matmul/matmul_core.sv
logic/fixed_cast.sv
logic/bias_repeat_buffer.sv
logic/register_slice.sv
logic/fixed_linear.sv
tb/tb_fixed_linear.sv

/* tb/tb_fixed_linear.sv */
`timescale 1ns/10ps

`include "linear_settings.svh"

module tb_fixed_linear;

  import linear_pkg::*;

  localparam logic [31:0] SEED = 32'h34e41fba;
  // Six tests of about 40 cycles each, with a wide margin for back-pressure
  localparam int TIMEOUT_CYCLES = 6 * 40 * 25;
  localparam int SETTLE_CYCLES  = 8;
  localparam int DATA_MAX       = 2 ** (`DATA_W - 1) - 1;
  localparam int DATA_MIN       = -(2 ** (`DATA_W - 1));

  typedef data_t [`LIN_BATCH-1:0][`LIN_IN-1:0] x_mat_t;
  typedef data_t [`LIN_OUT-1:0][`LIN_IN-1:0] w_mat_t;
  typedef bias_t [`LIN_OUT-1:0] bias_vec_t;
  typedef data_tile_t [ROW_BLOCKS*COL_BLOCKS-1:0] y_tiles_t;

  logic       clk = 1'b0;
  logic       i_rst;
  data_tile_t i_x;
  logic       i_x_valid;
  logic       o_x_ready;
  data_tile_t i_w;
  logic       i_w_valid;
  logic       o_w_ready;
  bias_tile_t i_b;
  logic       i_b_valid;
  logic       o_b_ready;
  data_tile_t o_y;
  logic       o_y_valid;
  logic       i_y_ready;

  data_tile_t  x_tiles[$];
  data_tile_t  w_tiles[$];
  bias_tile_t  b_tiles[$];
  data_tile_t  exp_q[$];
  logic [31:0] lcg_state;
  logic        gaps_on;
  logic        ready_random;
  string       cur_test;
  int          cycles;
  int          tests;
  int          checks;
  int          errors;
  int          test_errors;
  int          rx_count;
  int          exp_count;

  fixed_linear uut (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_x       (i_x),
    .i_x_valid (i_x_valid),
    .o_x_ready (o_x_ready),
    .i_w       (i_w),
    .i_w_valid (i_w_valid),
    .o_w_ready (o_w_ready),
    .i_b       (i_b),
    .i_b_valid (i_b_valid),
    .o_b_ready (o_b_ready),
    .o_y       (o_y),
    .o_y_valid (o_y_valid),
    .i_y_ready (i_y_ready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Signed value of about the given number of bits
  function automatic data_t rand_data(input int bits);
    lcg_state = lcg_next(lcg_state);
    return $signed(lcg_state[31:16]) >>> (`DATA_W - bits);
  endfunction

  // Large positive value in the upper quarter of the range
  function automatic data_t rand_large();
    lcg_state = lcg_next(lcg_state);
    return {2'b01, lcg_state[31:18]};
  endfunction

  function automatic bias_t rand_bias();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:24];
  endfunction

  // Y = X * W^T + b, element by element
  function automatic y_tiles_t ref_linear(input x_mat_t x, input w_mat_t w, input bias_vec_t b);
    y_tiles_t                 y;
    logic signed [`ACC_W-1:0] sum;
    logic signed [`ACC_W-1:0] shifted;
    data_t                    sat;
    data_t                    bias_ext;
    for (int r = 0; r < `LIN_BATCH; r++) begin
      for (int o = 0; o < `LIN_OUT; o++) begin
        sum = '0;
        for (int k = 0; k < `LIN_IN; k++) begin
          sum = sum + $signed(x[r][k]) * $signed(w[o][k]);
        end
        // Floor by arithmetic shift, then clamp
        shifted = sum >>> (2 * `DATA_FRAC - `DATA_FRAC);
        if (shifted > DATA_MAX) begin
          sat = DATA_MAX;
        end else if (shifted < DATA_MIN) begin
          sat = DATA_MIN;
        end else begin
          sat = shifted[`DATA_W-1:0];
        end
        bias_ext = {{(`DATA_W - `BIAS_W){b[o][`BIAS_W-1]}}, b[o]};
        bias_ext = bias_ext <<< (`DATA_FRAC - `BIAS_FRAC);
        y[(r / `LIN_PAR) * COL_BLOCKS + o / `LIN_PAR][r % `LIN_PAR][o % `LIN_PAR] = sat + bias_ext;
      end
    end
    return y;
  endfunction

  function automatic data_tile_t tile_at(input x_mat_t m, input int rb, input int cb);
    data_tile_t t;
    for (int r = 0; r < `LIN_PAR; r++) begin
      for (int c = 0; c < `LIN_PAR; c++) begin
        t[r][c] = m[rb * `LIN_PAR + r][cb * `LIN_PAR + c];
      end
    end
    return t;
  endfunction

  task automatic random_matrix(input int bits, output x_mat_t x, output w_mat_t w,
                               output bias_vec_t b);
    for (int r = 0; r < `LIN_BATCH; r++) begin
      for (int k = 0; k < `LIN_IN; k++) begin
        x[r][k] = rand_data(bits);
        w[r][k] = rand_data(bits);
      end
      b[r] = rand_bias();
    end
  endtask

  task automatic send_matrix(input x_mat_t x, input w_mat_t w, input bias_vec_t b);
    y_tiles_t   y;
    bias_tile_t bt;
    y = ref_linear(x, w, b);
    for (int rb = 0; rb < ROW_BLOCKS; rb++) begin
      for (int cb = 0; cb < DEPTH_BLOCKS; cb++) begin
        x_tiles.push_back(tile_at(x, rb, cb));
      end
    end
    // Weights stay in (out, in) block order
    for (int ob = 0; ob < COL_BLOCKS; ob++) begin
      for (int ib = 0; ib < DEPTH_BLOCKS; ib++) begin
        w_tiles.push_back(tile_at(w, ob, ib));
      end
    end
    for (int j = 0; j < COL_BLOCKS; j++) begin
      for (int c = 0; c < `LIN_PAR; c++) begin
        bt[c] = b[j * `LIN_PAR + c];
      end
      b_tiles.push_back(bt);
    end
    for (int t = 0; t < ROW_BLOCKS * COL_BLOCKS; t++) begin
      exp_q.push_back(y[t]);
      exp_count++;
    end
  endtask

  task automatic check_tile(input string name, input data_tile_t exp, input data_tile_t act);
    checks++;
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      $display("test %s: expected %0d result tiles, but %0d arrived", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    @(negedge clk);
    cur_test    = name;
    test_errors = 0;
    rx_count    = 0;
    exp_count   = 0;
  endtask

  task automatic finish_test();
    while (rx_count < exp_count) begin
      @(negedge clk);
    end
    // Room for a duplicate tile to show up
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_count(cur_test, exp_count, rx_count);
    $display("test %s done: %0d tiles, %0d errors", cur_test, rx_count, test_errors);
    tests++;
  endtask

  // Stream drivers hold each tile until it is taken
  initial begin
    logic [31:0] gap_rng;
    gap_rng = SEED ^ 32'h0000_0011;
    forever begin
      @(posedge clk);
      gap_rng = lcg_next(gap_rng);
      if (!i_x_valid || o_x_ready) begin
        if (x_tiles.size() > 0 && !(gaps_on && gap_rng[31:30] == 2'b00)) begin
          i_x       <= x_tiles.pop_front();
          i_x_valid <= 1'b1;
        end else begin
          i_x_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    logic [31:0] gap_rng;
    gap_rng = SEED ^ 32'h0000_2200;
    forever begin
      @(posedge clk);
      gap_rng = lcg_next(gap_rng);
      if (!i_w_valid || o_w_ready) begin
        if (w_tiles.size() > 0 && !(gaps_on && gap_rng[31:30] == 2'b00)) begin
          i_w       <= w_tiles.pop_front();
          i_w_valid <= 1'b1;
        end else begin
          i_w_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    logic [31:0] gap_rng;
    gap_rng = SEED ^ 32'h0033_0000;
    forever begin
      @(posedge clk);
      gap_rng = lcg_next(gap_rng);
      if (!i_b_valid || o_b_ready) begin
        if (b_tiles.size() > 0 && !(gaps_on && gap_rng[31:30] == 2'b00)) begin
          i_b       <= b_tiles.pop_front();
          i_b_valid <= 1'b1;
        end else begin
          i_b_valid <= 1'b0;
        end
      end
    end
  end

  // Output back-pressure
  initial begin
    logic [31:0] rdy_rng;
    rdy_rng = SEED ^ 32'h4400_0000;
    forever begin
      @(posedge clk);
      rdy_rng = lcg_next(rdy_rng);
      i_y_ready <= ready_random ? rdy_rng[31] : 1'b1;
    end
  end

  // Compare each accepted result against the expected queue
  always @(posedge clk) begin
    data_tile_t exp_tile;
    if (!i_rst && o_y_valid && i_y_ready) begin
      rx_count++;
      if (exp_q.size() == 0) begin
        $display("test %s: result tile %h arrived when none was expected", cur_test, o_y);
        errors++;
        test_errors++;
      end else begin
        exp_tile = exp_q.pop_front();
        check_tile(cur_test, exp_tile, o_y);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles in test %s, %0d of %0d result tiles arrived",
               cycles, cur_test, rx_count, exp_count);
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    x_mat_t    x;
    w_mat_t    w;
    bias_vec_t b;
    i_rst        = 1'b1;
    i_x          = '0;
    i_x_valid    = 1'b0;
    i_w          = '0;
    i_w_valid    = 1'b0;
    i_b          = '0;
    i_b_valid    = 1'b0;
    i_y_ready    = 1'b1;
    lcg_state    = SEED;
    gaps_on      = 1'b0;
    ready_random = 1'b0;
    cur_test     = "reset";
    cycles       = 0;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    repeat (2) @(posedge clk);
    i_rst <= 1'b0;

    // Weight of 1.0 on the diagonal
    start_test("identity");
    random_matrix(10, x, w, b);
    w = '0;
    b = '0;
    for (int k = 0; k < `LIN_IN; k++) begin
      w[k][k] = 1 << `DATA_FRAC;
    end
    send_matrix(x, w, b);
    finish_test();

    start_test("random");
    random_matrix(10, x, w, b);
    send_matrix(x, w, b);
    finish_test();

    // Out rows 0..1 saturate high, 2..3 low
    start_test("saturate");
    b = '0;
    for (int r = 0; r < `LIN_BATCH; r++) begin
      for (int k = 0; k < `LIN_IN; k++) begin
        x[r][k] = rand_large();
        w[r][k] = rand_large();
        if (r >= `LIN_OUT / 2) begin
          w[r][k] = -w[r][k];
        end
      end
    end
    send_matrix(x, w, b);
    finish_test();

    // Saturated rows plus bias wrap, zero rows show bias alone
    start_test("bias_wrap");
    for (int r = 0; r < `LIN_BATCH; r++) begin
      for (int k = 0; k < `LIN_IN; k++) begin
        x[r][k] = (r < 2) ? rand_large() : '0;
        w[r][k] = rand_large();
      end
    end
    b[0] = 8'sh7f;
    b[1] = 8'sh80;
    b[2] = 8'shff;
    b[3] = 8'shc3;
    send_matrix(x, w, b);
    finish_test();

    start_test("backpressure");
    gaps_on      = 1'b1;
    ready_random = 1'b1;
    for (int m = 0; m < 2; m++) begin
      random_matrix(11, x, w, b);
      send_matrix(x, w, b);
    end
    finish_test();
    gaps_on      = 1'b0;
    ready_random = 1'b0;

    start_test("back_to_back");
    for (int m = 0; m < 3; m++) begin
      random_matrix(12, x, w, b);
      send_matrix(x, w, b);
    end
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* logic/fixed_linear.sv */
`timescale 1ns/10ps

`include "linear_settings.svh"

module fixed_linear (
  input  logic                   clk,
  input  logic                   i_rst,
  input  linear_pkg::data_tile_t i_x,
  input  logic                   i_x_valid,
  output logic                   o_x_ready,
  input  linear_pkg::data_tile_t i_w,
  input  logic                   i_w_valid,
  output logic                   o_w_ready,
  input  linear_pkg::bias_tile_t i_b,
  input  logic                   i_b_valid,
  output logic                   o_b_ready,
  output linear_pkg::data_tile_t o_y,
  output logic                   o_y_valid,
  input  logic                   i_y_ready
);

  import linear_pkg::*;

  data_tile_t                 wt_data;
  logic                       wt_valid;
  logic                       wt_ready;
  acc_tile_t                  mm_data;
  logic                       mm_valid;
  logic                       mm_ready;
  bias_tile_t                 bb_data;
  logic                       bb_valid;
  logic                       bb_ready;
  data_tile_t                 mm_cast;
  data_t [`LIN_PAR-1:0]       bias_cast;
  data_tile_t                 sum_tile;
  logic                       sum_valid;
  logic                       sum_ready;

  // Weights come in (out, in) order
  matrix_stream_transpose weight_transpose_i (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_data  (i_w),
    .i_valid (i_w_valid),
    .o_ready (o_w_ready),
    .o_data  (wt_data),
    .o_valid (wt_valid),
    .i_ready (wt_ready)
  );

  matmul_core matmul_i (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_a_data  (i_x),
    .i_a_valid (i_x_valid),
    .o_a_ready (o_x_ready),
    .i_b_data  (wt_data),
    .i_b_valid (wt_valid),
    .o_b_ready (wt_ready),
    .o_data    (mm_data),
    .o_valid   (mm_valid),
    .i_ready   (mm_ready)
  );

  bias_repeat_buffer bias_buffer_i (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_data  (i_b),
    .i_valid (i_b_valid),
    .o_ready (o_b_ready),
    .o_data  (bb_data),
    .o_valid (bb_valid),
    .i_ready (bb_ready)
  );

  // Sums from 40/6 down to output format
  fixed_cast #(
    .IN_W     (`ACC_W),
    .IN_FRAC  (ACC_FRAC),
    .OUT_W    (`DATA_W),
    .OUT_FRAC (`DATA_FRAC),
    .N        (`LIN_PAR * `LIN_PAR)
  ) acc_cast_i (
    .i_data (mm_data),
    .o_data (mm_cast)
  );

  fixed_cast #(
    .IN_W     (`BIAS_W),
    .IN_FRAC  (`BIAS_FRAC),
    .OUT_W    (`DATA_W),
    .OUT_FRAC (`DATA_FRAC),
    .N        (`LIN_PAR)
  ) bias_cast_i (
    .i_data (bb_data),
    .o_data (bias_cast)
  );

  // Join matmul and bias streams
  assign sum_valid = mm_valid && bb_valid;
  assign mm_ready  = bb_valid && sum_ready;
  assign bb_ready  = mm_valid && sum_ready;

  // Wrapping add, bias column j goes to every row of column j
  always_comb begin
    for (int r = 0; r < `LIN_PAR; r++) begin
      for (int c = 0; c < `LIN_PAR; c++) begin
        sum_tile[r][c] = mm_cast[r][c] + bias_cast[c];
      end
    end
  end

  register_slice #(
    .T (data_tile_t)
  ) out_slice_i (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_data  (sum_tile),
    .i_valid (sum_valid),
    .o_ready (sum_ready),
    .o_data  (o_y),
    .o_valid (o_y_valid),
    .i_ready (i_y_ready)
  );

endmodule

/* logic/register_slice.sv */
`timescale 1ns/10ps

module register_slice #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic i_rst,
  input  T     i_data,
  input  logic i_valid,
  output logic o_ready,
  output T     o_data,
  output logic o_valid,
  input  logic i_ready
);

  T     main_q;
  T     skid_q;
  logic main_vld_q;
  logic skid_vld_q;
  logic accept;
  logic main_free;

  // Ready comes straight from a flop
  assign o_ready   = !skid_vld_q;
  assign o_valid   = main_vld_q;
  assign o_data    = main_q;
  assign accept    = i_valid && o_ready;
  assign main_free = !main_vld_q || i_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (main_free) begin
      if (skid_vld_q) begin
        main_vld_q <= 1'b1;
        skid_vld_q <= 1'b0;
      end else begin
        main_vld_q <= accept;
      end
    end else if (accept) begin
      skid_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_q <= skid_vld_q ? skid_q : i_data;
    end else if (accept) begin
      skid_q <= i_data;
    end
  end

  // A tile caught in the skid entry closes the input until it moves on
  a_no_accept_full : assert property (@(posedge clk) disable iff (i_rst)
    (accept && main_vld_q && !i_ready) |=> !o_ready)
    else $error("register slice accepted input with both entries full");

endmodule

/* logic/bias_repeat_buffer.sv */
`timescale 1ns/10ps

module bias_repeat_buffer (
  input  logic                   clk,
  input  logic                   i_rst,
  input  linear_pkg::bias_tile_t i_data,
  input  logic                   i_valid,
  output logic                   o_ready,
  output linear_pkg::bias_tile_t o_data,
  output logic                   o_valid,
  input  logic                   i_ready
);

  import linear_pkg::*;

  localparam int T_W   = $clog2(COL_BLOCKS);
  localparam int REP_W = $clog2(ROW_BLOCKS + 1);

  typedef enum logic {
    S_FILL,
    S_PLAY
  } state_t;

  state_t           state_q;
  logic [T_W-1:0]   cnt_q;
  logic [REP_W-1:0] rep_q;
  bias_tile_t       mem_q [COL_BLOCKS];

  assign o_ready = (state_q == S_FILL);
  assign o_valid = (state_q == S_PLAY);
  assign o_data  = mem_q[cnt_q];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= S_FILL;
      cnt_q   <= '0;
      rep_q   <= '0;
    end else if (state_q == S_FILL) begin
      if (i_valid) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == T_W'(COL_BLOCKS - 1)) begin
          cnt_q   <= '0;
          state_q <= S_PLAY;
        end
      end
    end else if (i_ready) begin
      cnt_q <= cnt_q + 1'b1;
      // End of one pass over the bias vector
      if (cnt_q == T_W'(COL_BLOCKS - 1)) begin
        cnt_q <= '0;
        if (rep_q == REP_W'(ROW_BLOCKS - 1)) begin
          rep_q   <= '0;
          state_q <= S_FILL;
        end else begin
          rep_q <= rep_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      mem_q[cnt_q] <= i_data;
    end
  end

  a_rep_bound : assert property (@(posedge clk) disable iff (i_rst)
    rep_q < REP_W'(ROW_BLOCKS))
    else $error("bias replayed more often than there are row blocks");

endmodule

/* logic/fixed_cast.sv */
`timescale 1ns/10ps

module fixed_cast #(
  parameter int IN_W     = 40,
  parameter int IN_FRAC  = 6,
  parameter int OUT_W    = 16,
  parameter int OUT_FRAC = 3,
  parameter int N        = 4
) (
  input  logic [N-1:0][IN_W-1:0]  i_data,
  output logic [N-1:0][OUT_W-1:0] o_data
);

  localparam int L_SH   = (OUT_FRAC > IN_FRAC) ? OUT_FRAC - IN_FRAC : 0;
  localparam int R_SH   = (IN_FRAC > OUT_FRAC) ? IN_FRAC - OUT_FRAC : 0;
  localparam int WIDE_W = (IN_W + L_SH > OUT_W) ? IN_W + L_SH : OUT_W;

  // Output range, held at the working width
  localparam logic signed [WIDE_W-1:0] MAX_V = {{(WIDE_W - OUT_W + 1){1'b0}}, {(OUT_W - 1){1'b1}}};
  localparam logic signed [WIDE_W-1:0] MIN_V = ~MAX_V;

  always_comb begin
    logic signed [WIDE_W-1:0] wide;
    logic signed [WIDE_W-1:0] aligned;
    for (int n = 0; n < N; n++) begin
      wide = $signed(i_data[n]);
      // Arithmetic right shift floors toward minus infinity
      aligned = (wide <<< L_SH) >>> R_SH;
      if (aligned > MAX_V) begin
        o_data[n] = MAX_V[OUT_W-1:0];
      end else if (aligned < MIN_V) begin
        o_data[n] = MIN_V[OUT_W-1:0];
      end else begin
        o_data[n] = aligned[OUT_W-1:0];
      end
    end
  end

endmodule

/* matmul/matmul_core.sv */
`timescale 1ns/10ps

`include "linear_settings.svh"

module matmul_core (
  input  logic                   clk,
  input  logic                   i_rst,
  input  linear_pkg::data_tile_t i_a_data,
  input  logic                   i_a_valid,
  output logic                   o_a_ready,
  input  linear_pkg::data_tile_t i_b_data,
  input  logic                   i_b_valid,
  output logic                   o_b_ready,
  output linear_pkg::acc_tile_t  o_data,
  output logic                   o_valid,
  input  logic                   i_ready
);

  import linear_pkg::*;

  localparam int B_CNT_W = $clog2(W_TILES);
  localparam int K_W     = $clog2(DEPTH_BLOCKS);
  localparam int J_W     = $clog2(COL_BLOCKS);
  localparam int RB_W    = $clog2(ROW_BLOCKS);

  typedef enum logic [1:0] {
    S_LOAD_B,
    S_LOAD_A,
    S_ACC,
    S_OUT
  } state_t;

  state_t             state_q;
  logic [B_CNT_W-1:0] b_cnt_q;
  logic [K_W-1:0]     k_q;
  logic [J_W-1:0]     j_q;
  logic [RB_W-1:0]    rb_q;
  logic [B_CNT_W-1:0] w_idx;
  data_tile_t         wt_q  [W_TILES];
  data_tile_t         x_q   [DEPTH_BLOCKS];
  acc_tile_t          acc_q;
  acc_tile_t          acc_next;

  assign o_b_ready = (state_q == S_LOAD_B);
  assign o_a_ready = (state_q == S_LOAD_A);
  assign o_valid   = (state_q == S_OUT);
  assign o_data    = acc_q;

  // One depth step: 8 products into the running sums
  always_comb begin
    logic signed [2*`DATA_W-1:0] prod;
    w_idx = B_CNT_W'(k_q * COL_BLOCKS + j_q);
    for (int i = 0; i < `LIN_PAR; i++) begin
      for (int n = 0; n < `LIN_PAR; n++) begin
        acc_next[i][n] = (k_q == '0) ? '0 : acc_q[i][n];
        for (int d = 0; d < `LIN_PAR; d++) begin
          prod = $signed(x_q[k_q][i][d]) * $signed(wt_q[w_idx][d][n]);
          acc_next[i][n] = $signed(acc_next[i][n]) + prod;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= S_LOAD_B;
      b_cnt_q <= '0;
      k_q     <= '0;
      j_q     <= '0;
      rb_q    <= '0;
    end else begin
      case (state_q)
        S_LOAD_B: begin
          if (i_b_valid) begin
            b_cnt_q <= b_cnt_q + 1'b1;
            if (b_cnt_q == B_CNT_W'(W_TILES - 1)) begin
              b_cnt_q <= '0;
              state_q <= S_LOAD_A;
            end
          end
        end
        // k_q counts X tiles here, depth steps in S_ACC
        S_LOAD_A: begin
          if (i_a_valid) begin
            k_q <= k_q + 1'b1;
            if (k_q == K_W'(DEPTH_BLOCKS - 1)) begin
              k_q     <= '0;
              state_q <= S_ACC;
            end
          end
        end
        S_ACC: begin
          k_q <= k_q + 1'b1;
          if (k_q == K_W'(DEPTH_BLOCKS - 1)) begin
            k_q     <= '0;
            state_q <= S_OUT;
          end
        end
        default: begin
          if (i_ready) begin
            if (j_q == J_W'(COL_BLOCKS - 1)) begin
              j_q <= '0;
              if (rb_q == RB_W'(ROW_BLOCKS - 1)) begin
                rb_q    <= '0;
                state_q <= S_LOAD_B;
              end else begin
                rb_q    <= rb_q + 1'b1;
                state_q <= S_LOAD_A;
              end
            end else begin
              j_q     <= j_q + 1'b1;
              state_q <= S_ACC;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_b_ready && i_b_valid) begin
      wt_q[b_cnt_q] <= i_b_data;
    end
    if (o_a_ready && i_a_valid) begin
      x_q[k_q] <= i_a_data;
    end
    if (state_q == S_ACC) begin
      acc_q <= acc_next;
    end
  end

  a_out_stable : assert property (@(posedge clk) disable iff (i_rst)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)))
    else $error("matmul output changed while stalled");

endmodule

/* logic/matrix_stream_transpose.sv */
`timescale 1ns/10ps

`include "linear_settings.svh"

module matrix_stream_transpose (
  input  logic                   clk,
  input  logic                   i_rst,
  input  linear_pkg::data_tile_t i_data,
  input  logic                   i_valid,
  output logic                   o_ready,
  output linear_pkg::data_tile_t o_data,
  output logic                   o_valid,
  input  logic                   i_ready
);

  import linear_pkg::*;

  localparam int CNT_W = $clog2(W_TILES);

  typedef enum logic {
    S_FILL,
    S_DRAIN
  } state_t;

  state_t           state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] src_idx;
  data_tile_t       mem_q   [W_TILES];
  data_tile_t       src_tile;

  assign o_ready = (state_q == S_FILL);
  assign o_valid = (state_q == S_DRAIN);

  // Output tile (r, c) comes from stored tile (c, r)
  always_comb begin
    src_idx  = CNT_W'((cnt_q % COL_BLOCKS) * DEPTH_BLOCKS + cnt_q / COL_BLOCKS);
    src_tile = mem_q[src_idx];
    for (int r = 0; r < `LIN_PAR; r++) begin
      for (int c = 0; c < `LIN_PAR; c++) begin
        o_data[r][c] = src_tile[c][r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= S_FILL;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_FILL: begin
          if (i_valid) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(W_TILES - 1)) begin
              cnt_q   <= '0;
              state_q <= S_DRAIN;
            end
          end
        end
        default: begin
          if (i_ready) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(W_TILES - 1)) begin
              cnt_q   <= '0;
              state_q <= S_FILL;
            end
          end
        end
      endcase
    end
  end

  // Arrival order is (out block, in block), row-major
  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      mem_q[cnt_q] <= i_data;
    end
  end

  // Once a matrix is complete, input stays closed for the whole drain
  a_no_fill_while_drain : assert property (@(posedge clk) disable iff (i_rst)
    (i_valid && o_ready && cnt_q == CNT_W'(W_TILES - 1)) |=> !o_ready [*W_TILES])
    else $error("transpose accepted a tile while draining");

endmodule

/* common/linear_pkg.sv */
package linear_pkg;

  `include "linear_settings.svh"

  // Element types
  typedef logic signed [`DATA_W-1:0] data_t;
  typedef logic signed [`BIAS_W-1:0] bias_t;
  typedef logic signed [`ACC_W-1:0] acc_t;

  // Tiles, indexed [row][col]
  typedef data_t [`LIN_PAR-1:0][`LIN_PAR-1:0] data_tile_t;
  typedef acc_t [`LIN_PAR-1:0][`LIN_PAR-1:0] acc_tile_t;

  // One bias per output column of a tile
  typedef bias_t [`LIN_PAR-1:0] bias_tile_t;

  // Row blocks of X
  localparam int ROW_BLOCKS = `LIN_BATCH / `LIN_PAR;

  // Blocks along the reduction dimension
  localparam int DEPTH_BLOCKS = `LIN_IN / `LIN_PAR;

  // Output column blocks
  localparam int COL_BLOCKS = `LIN_OUT / `LIN_PAR;

  // Tiles in a full weight matrix
  localparam int W_TILES = DEPTH_BLOCKS * COL_BLOCKS;

  // Product of two data values carries both fractions
  localparam int ACC_FRAC = 2 * `DATA_FRAC;

endpackage

/* common/linear_settings.svh */
`ifndef LINEAR_SETTINGS_SVH
`define LINEAR_SETTINGS_SVH

// Tile edge, elements per side
`define LIN_PAR 2

// Tensor sizes
`define LIN_BATCH 4
`define LIN_IN 4
`define LIN_OUT 4

// Data and weight format
`define DATA_W 16
`define DATA_FRAC 3

// Bias format
`define BIAS_W 8
`define BIAS_FRAC 2

// Full-width accumulator
`define ACC_W 40

`endif
